// File: Makefile
TOP := tb_mgmt_qspi_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

obj_dir/$(TOP): mgmt_qspi_top.f hw/*.sv testbench/*.sv testbench/*.svh
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f mgmt_qspi_top.f -o $(TOP)

test: obj_dir/$(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: hw/bank_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module bank_decoder #(
	parameter int num_banks      = 4,
	parameter int bank_addr_bits = 6
) (
	input  wire                                   clk,
	input  wire                                   reset,
	input  wire mgmt_pkg::mgmt_req_t              req,
	output mgmt_pkg::bank_req_t [num_banks-1:0]   bank_req,
	output logic [$clog2(num_banks)-1:0]          rd_sel,
	output logic                                  rd_unmapped,
	output logic                                  rd_pending
);

	localparam int sel_bits     = $clog2(num_banks);
	localparam int mapped_limit = num_banks << bank_addr_bits;

	// Bank index sits right above the in-bank offset
	logic [sel_bits-1:0] sel;
	logic                mapped;

	assign sel    = req.addr[bank_addr_bits +: sel_bits];
	assign mapped = int'(req.addr) < mapped_limit;

	always_ff @(posedge clk) begin
		for (int i = 0; i < num_banks; i++) begin
			bank_req[i].offset <= 16'(req.addr[bank_addr_bits-1:0]);
			bank_req[i].wdata  <= req.wdata;
			if (reset) begin
				bank_req[i].rd <= 1'b0;
				bank_req[i].wr <= 1'b0;
			end else begin
				// Unmapped accesses strobe nothing
				bank_req[i].rd <= req.rd && mapped && sel == sel_bits'(i);
				bank_req[i].wr <= req.wr && mapped && sel == sel_bits'(i);
			end
		end
	end

	// Side info so the collector answers every read
	always_ff @(posedge clk) begin
		rd_sel <= sel;
		if (reset) begin
			rd_unmapped <= 1'b0;
			rd_pending  <= 1'b0;
		end else begin
			rd_unmapped <= req.rd && !mapped;
			rd_pending  <= req.rd;
		end
	end

endmodule

`default_nettype wire

// File: hw/management_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module management_bridge (
	input  wire                 clk,
	input  wire                 reset,

	// From the QSPI device interface
	input  wire                 start,
	input  wire                 insn_valid,
	input  wire mgmt_pkg::addr_t insn,
	input  wire                 wr_valid,
	input  wire [7:0]           wr_data,
	output logic                rd_mode,
	input  wire                 rd_ready,

	// Access toward the bank decoder
	output mgmt_pkg::mgmt_req_t req
);

	import mgmt_pkg::*;

	////////////////////////////////////////////////////////////
	// Address counters

	// Separate pointers, each bumps after its own strobe
	addr_t rd_addr;
	addr_t wr_addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_addr <= '0;
			wr_addr <= '0;
		end else if (insn_valid) begin
			// Low 15 bits give the start address
			rd_addr <= {1'b0, insn[14:0]};
			wr_addr <= {1'b0, insn[14:0]};
		end else begin
			if (rd_ready)
				rd_addr <= rd_addr + 16'd1;
			if (wr_valid)
				wr_addr <= wr_addr + 16'd1;
		end
	end

	// Direction, cleared at every new frame
	always_ff @(posedge clk) begin
		if (reset || start)
			rd_mode <= 1'b0;
		else if (insn_valid)
			rd_mode <= ~insn[15];
	end

	////////////////////////////////////////////////////////////
	// Request out, same cycle as the strobe

	always_comb begin
		req       = '0;
		req.rd    = rd_ready;
		req.wr    = wr_valid;
		req.addr  = rd_ready ? rd_addr : wr_addr;
		req.wdata = wr_data;
	end

	a_single_dir: assert property (@(posedge clk) disable iff (reset)
		!(req.rd && req.wr));

endmodule

`default_nettype wire

// File: hw/mgmt_pkg.sv
`default_nettype none

package mgmt_pkg;

	////////////////////////////////////////////////////////////
	// Protocol constants

	// Instruction length on the wire, in bytes
	localparam int insn_bytes = 2;

	// Idle sck cycles between instruction and first read nibble
	localparam int dummy_cycles = 4;

	////////////////////////////////////////////////////////////
	// Access types

	// Byte address into the register space
	typedef logic [15:0] addr_t;

	// Bridge to decoder, valid only while rd or wr is set
	typedef struct packed {
		logic       rd;
		logic       wr;
		addr_t      addr;
		logic [7:0] wdata;
	} mgmt_req_t;

	// Decoder to one bank
	// Offset is full width, bank uses only its low bits
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [15:0] offset;
		logic [7:0]  wdata;
	} bank_req_t;

endpackage

`default_nettype wire

// File: hw/mgmt_qspi_top.sv
`timescale 1ns/1ns
`default_nettype none

module mgmt_qspi_top #(
	parameter int num_banks      = 4,
	parameter int bank_addr_bits = 6
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        sck,
	input  wire        cs_n,
	input  wire [3:0]  dq_in,
	output logic [3:0] dq_out,
	output logic       dq_oe
);

	import mgmt_pkg::*;

	////////////////////////////////////////////////////////////
	// Interface to bridge

	logic       start;
	logic       insn_valid;
	addr_t      insn;
	logic       wr_valid;
	logic [7:0] wr_data;
	logic       rd_mode;
	logic       rd_ready;
	logic       rd_valid;
	logic [7:0] rd_data;

	qspi_device_interface qspi_i (
		.clk        (clk),
		.reset      (reset),
		.sck        (sck),
		.cs_n       (cs_n),
		.dq_in      (dq_in),
		.dq_out     (dq_out),
		.dq_oe      (dq_oe),
		.start      (start),
		.insn_valid (insn_valid),
		.insn       (insn),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.rd_mode    (rd_mode),
		.rd_ready   (rd_ready),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

	mgmt_req_t req;

	management_bridge bridge_i (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.insn_valid (insn_valid),
		.insn       (insn),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.rd_mode    (rd_mode),
		.rd_ready   (rd_ready),
		.req        (req)
	);

	////////////////////////////////////////////////////////////
	// Decode, banks, read return

	bank_req_t [num_banks-1:0]      bank_req;
	logic [$clog2(num_banks)-1:0]   rd_sel;
	logic                           rd_unmapped;
	logic                           rd_pending;
	logic [num_banks-1:0]           bank_rvalid;
	logic [num_banks-1:0][7:0]      bank_rdata;

	bank_decoder #(
		.num_banks      (num_banks),
		.bank_addr_bits (bank_addr_bits)
	) decoder_i (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.bank_req    (bank_req),
		.rd_sel      (rd_sel),
		.rd_unmapped (rd_unmapped),
		.rd_pending  (rd_pending)
	);

	// One bank per index
	for (genvar i = 0; i < num_banks; i++) begin : g_bank
		register_bank #(
			.bank_addr_bits (bank_addr_bits)
		) bank_i (
			.clk    (clk),
			.reset  (reset),
			.breq   (bank_req[i]),
			.rvalid (bank_rvalid[i]),
			.rdata  (bank_rdata[i])
		);
	end

	read_collector #(
		.num_banks (num_banks)
	) collector_i (
		.clk         (clk),
		.reset       (reset),
		.rd_sel      (rd_sel),
		.rd_unmapped (rd_unmapped),
		.rd_pending  (rd_pending),
		.bank_rvalid (bank_rvalid),
		.bank_rdata  (bank_rdata),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

endmodule

`default_nettype wire

// File: hw/qspi_device_interface.sv
`timescale 1ns/1ns
`default_nettype none

module qspi_device_interface (
	input  wire             clk,
	input  wire             reset,

	// QSPI pins
	input  wire             sck,
	input  wire             cs_n,
	input  wire [3:0]       dq_in,
	output logic [3:0]      dq_out,
	output logic            dq_oe,

	// Frame events toward the bridge
	output logic            start,
	output logic            insn_valid,
	output mgmt_pkg::addr_t insn,
	output logic            wr_valid,
	output logic [7:0]      wr_data,

	// Read data path
	input  wire             rd_mode,
	output logic            rd_ready,
	input  wire             rd_valid,
	input  wire [7:0]       rd_data
);

	import mgmt_pkg::*;

	localparam int insn_nibbles = insn_bytes * 2;

	typedef enum logic [1:0] {ph_idle, ph_insn, ph_turn, ph_data} phase_t;

	////////////////////////////////////////////////////////////
	// Pin synchronizers

	// Two flops for metastability, third for edge detect
	logic [2:0] sck_sync;
	logic [2:0] cs_sync;
	logic [3:0] dq_sync1;
	logic [3:0] dq_s;

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync <= 3'b000;
			cs_sync  <= 3'b111;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
			cs_sync  <= {cs_sync[1:0], cs_n};
		end
	end

	// Data delayed to line up with sck_sync[1]
	always_ff @(posedge clk) begin
		dq_sync1 <= dq_in;
		dq_s     <= dq_sync1;
	end

	logic sck_rise;
	logic sck_fall;
	logic cs_active;
	logic cs_fall;

	assign sck_rise  = sck_sync[1] & ~sck_sync[2];
	assign sck_fall  = ~sck_sync[1] & sck_sync[2];
	assign cs_active = ~cs_sync[1];
	assign cs_fall   = ~cs_sync[1] & cs_sync[2];

	////////////////////////////////////////////////////////////
	// Frame sequencing

	phase_t     phase;
	logic [3:0] nib_cnt;
	logic [3:0] turn_cnt;
	logic       nib_odd;
	logic       wr_frame;
	logic [7:0] rd_buf;
	logic [3:0] tx_lo;
	addr_t      insn_next;

	// Instruction shifts in MSB nibble first
	assign insn_next = {insn[11:0], dq_s};

	always_ff @(posedge clk) begin
		start      <= 1'b0;
		insn_valid <= 1'b0;
		wr_valid   <= 1'b0;
		rd_ready   <= 1'b0;
		if (reset) begin
			phase    <= ph_idle;
			nib_cnt  <= '0;
			turn_cnt <= '0;
			nib_odd  <= 1'b0;
			wr_frame <= 1'b0;
			dq_out   <= 4'h0;
			dq_oe    <= 1'b0;
		end else if (!cs_active) begin
			// Frame over, partial byte simply dropped
			phase <= ph_idle;
			dq_oe <= 1'b0;
		end else if (cs_fall) begin
			start    <= 1'b1;
			phase    <= ph_insn;
			nib_cnt  <= '0;
			turn_cnt <= '0;
			nib_odd  <= 1'b0;
		end else begin
			case (phase)
				ph_insn: begin
					if (sck_rise) begin
						nib_cnt <= nib_cnt + 4'd1;
						if (nib_cnt == 4'(insn_nibbles - 1)) begin
							insn_valid <= 1'b1;
							// MSB set means write, data follows directly
							wr_frame   <= insn_next[15];
							phase      <= insn_next[15] ? ph_data : ph_turn;
						end
					end
				end
				ph_turn: begin
					if (sck_rise) begin
						// Prefetch first byte early in turnaround
						if (turn_cnt == 4'd0)
							rd_ready <= 1'b1;
						turn_cnt <= turn_cnt + 4'd1;
						if (turn_cnt == 4'(dummy_cycles - 1))
							phase <= ph_data;
					end
				end
				ph_data: begin
					if (wr_frame) begin
						if (sck_rise) begin
							nib_odd  <= ~nib_odd;
							wr_valid <= nib_odd;
						end
					end else if (sck_fall) begin
						// High nibble straight from the prefetch buffer
						nib_odd <= ~nib_odd;
						dq_oe   <= 1'b1;
						dq_out  <= nib_odd ? tx_lo : rd_buf[7:4];
						// Ask for the next byte at each byte boundary
						rd_ready <= ~nib_odd;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// Shift and buffer registers
	always_ff @(posedge clk) begin
		if (phase == ph_insn && sck_rise)
			insn <= insn_next;
		if (phase == ph_data && wr_frame && sck_rise)
			wr_data <= {wr_data[3:0], dq_s};
		if (phase == ph_data && !wr_frame && sck_fall && !nib_odd)
			tx_lo <= rd_buf[3:0];
		if (rd_valid)
			rd_buf <= rd_data;
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Requests still in the pipeline, may outlive the frame
	logic [1:0] rd_outstanding;

	always_ff @(posedge clk) begin
		if (reset)
			rd_outstanding <= 2'd0;
		else if (rd_ready && !rd_valid)
			rd_outstanding <= rd_outstanding + 2'd1;
		else if (!rd_ready && rd_valid)
			rd_outstanding <= rd_outstanding - 2'd1;
	end

	a_rd_valid_requested: assert property (@(posedge clk) disable iff (reset)
		rd_valid |-> rd_outstanding != 2'd0);

	// Local frame type must agree with bridge direction
	a_no_write_in_read: assert property (@(posedge clk) disable iff (reset)
		wr_valid |-> !rd_mode);

endmodule

`default_nettype wire

// File: hw/read_collector.sv
`timescale 1ns/1ns
`default_nettype none

module read_collector #(
	parameter int num_banks = 4
) (
	input  wire                                clk,
	input  wire                                reset,
	input  wire [$clog2(num_banks)-1:0]        rd_sel,
	input  wire                                rd_unmapped,
	input  wire                                rd_pending,
	input  wire [num_banks-1:0]                bank_rvalid,
	input  wire [num_banks-1:0][7:0]           bank_rdata,
	output logic                               rd_valid,
	output logic [7:0]                         rd_data
);

	localparam int sel_bits = $clog2(num_banks);

	// Select info one cycle late, same stage as bank output
	logic [sel_bits-1:0] sel_q;
	logic                unmapped_q;
	logic                pending_q;

	always_ff @(posedge clk) begin
		sel_q <= rd_sel;
		if (reset) begin
			unmapped_q <= 1'b0;
			pending_q  <= 1'b0;
			rd_valid   <= 1'b0;
		end else begin
			unmapped_q <= rd_unmapped;
			pending_q  <= rd_pending;
			rd_valid   <= pending_q;
		end
	end

	// Unmapped reads answer with zero
	always_ff @(posedge clk) begin
		if (bank_rvalid[sel_q] && !unmapped_q)
			rd_data <= bank_rdata[sel_q];
		else
			rd_data <= 8'h00;
	end

	// Exactly the selected bank responds, and only for a mapped read
	a_rvalid_matches: assert property (@(posedge clk) disable iff (reset)
		bank_rvalid == ((pending_q && !unmapped_q) ? num_banks'(1) << sel_q : '0));

endmodule

`default_nettype wire

// File: hw/register_bank.sv
`timescale 1ns/1ns
`default_nettype none

module register_bank #(
	parameter int bank_addr_bits = 6
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire mgmt_pkg::bank_req_t breq,
	output logic                     rvalid,
	output logic [7:0]               rdata
);

	localparam int depth = 2 ** bank_addr_bits;

	////////////////////////////////////////////////////////////
	// Storage

	logic [7:0]                regs [depth];
	logic [bank_addr_bits-1:0] idx;

	// Upper offset bits never reach this bank
	assign idx = breq.offset[bank_addr_bits-1:0];

	// Contents must read back as zero after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < depth; i++)
				regs[i] <= 8'h00;
		end else if (breq.wr) begin
			regs[idx] <= breq.wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Registered read port

	// One cycle from strobe to data
	always_ff @(posedge clk) begin
		if (breq.rd)
			rdata <= regs[idx];
	end

	// Valid flag lines up with rdata
	always_ff @(posedge clk) begin
		if (reset)
			rvalid <= 1'b0;
		else
			rvalid <= breq.rd;
	end

endmodule

`default_nettype wire

// File: mgmt_qspi_top.f
+incdir+testbench
hw/mgmt_pkg.sv
hw/qspi_device_interface.sv
hw/management_bridge.sv
hw/bank_decoder.sv
hw/register_bank.sv
hw/read_collector.sv
hw/mgmt_qspi_top.sv
testbench/tb_mgmt_qspi_top.sv

// File: testbench/qspi_host_tasks.svh
`ifndef QSPI_HOST_TASKS_SVH
`define QSPI_HOST_TASKS_SVH

////////////////////////////////////////////////////////////
// QSPI host side, mode 0, sck idle low

// Half sck period in clk cycles
localparam int half_clks = 5;

// Step to just after a rising clk edge
task automatic wait_clks(input int n);
	repeat (n) begin
		@(posedge clk);
		#1;
	end
endtask

// Full sck cycle, host data already on dq_in
task automatic sck_pulse();
	wait_clks(half_clks);
	sck = 1'b1;
	wait_clks(half_clks);
	sck = 1'b0;
endtask

// Host drives, device must stay off the bus
task automatic send_nibble(input logic [3:0] nib);
	dq_in = nib;
	check("dq_oe", 32'(dq_oe), 32'h0);
	sck_pulse();
endtask

// cs_n low, then instruction MSB nibble first
task automatic open_frame(input logic [15:0] insn);
	cs_n = 1'b0;
	for (int i = 3; i >= 0; i--)
		send_nibble(insn[i*4 +: 4]);
endtask

task automatic close_frame();
	int cnt;
	wait_clks(half_clks);
	cs_n = 1'b1;
	dq_in = 4'h0;
	cnt = 0;
	// Device releases dq once it sees cs_n high
	while (dq_oe) begin
		if (cnt == 2 * half_clks) begin
			$display("Timeout: dq_oe still high after cs_n rose");
			stop_on_error();
		end
		wait_clks(1);
		cnt++;
	end
	// Idle gap between frames
	wait_clks(2 * half_clks);
	check("dq_oe", 32'(dq_oe), 32'h0);
endtask

// First read nibble, wait for the device to take the bus
task automatic await_drive();
	int cnt;
	cnt = 0;
	while (!dq_oe) begin
		if (cnt == half_clks) begin
			$display("Timeout: dq_oe never went high for read data");
			stop_on_error();
		end
		wait_clks(1);
		cnt++;
	end
	wait_clks(half_clks - cnt);
endtask

// Sample just before rising sck
task automatic sample_nibble(input bit first, output logic [3:0] nib);
	if (first)
		await_drive();
	else
		wait_clks(half_clks);
	check("dq_oe", 32'(dq_oe), 32'h1);
	nib = dq_out;
	sck = 1'b1;
	wait_clks(half_clks);
	sck = 1'b0;
endtask

// Bytes come from burst_buf
task automatic qspi_write_burst(input logic [15:0] addr, input int len);
	open_frame({1'b1, addr[14:0]});
	for (int i = 0; i < len; i++) begin
		send_nibble(burst_buf[i][7:4]);
		send_nibble(burst_buf[i][3:0]);
	end
	close_frame();
endtask

// Bytes land in burst_buf
task automatic qspi_read_burst(input logic [15:0] addr, input int len);
	logic [3:0] hi;
	logic [3:0] lo;
	open_frame({1'b0, addr[14:0]});
	// Turnaround, nobody drives
	dq_in = 4'h0;
	for (int i = 0; i < mgmt_pkg::dummy_cycles; i++) begin
		check("dq_oe", 32'(dq_oe), 32'h0);
		sck_pulse();
	end
	for (int i = 0; i < len; i++) begin
		sample_nibble(i == 0, hi);
		sample_nibble(1'b0, lo);
		burst_buf[i] = {hi, lo};
	end
	close_frame();
endtask

`endif

// File: testbench/tb_mgmt_qspi_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mgmt_qspi_top;

	localparam int num_banks   = 4;
	localparam int bank_size   = 64;
	localparam int mapped_size = num_banks * bank_size;

	logic       clk;
	logic       reset;
	logic       sck;
	logic       cs_n;
	logic [3:0] dq_in;
	logic [3:0] dq_out;
	logic       dq_oe;

	// Expected register contents, mapped space only
	logic [7:0] exp_mem [mapped_size];
	// Data of the current burst
	logic [7:0] burst_buf [64];

	mgmt_qspi_top dut_i (
		.clk    (clk),
		.reset  (reset),
		.sck    (sck),
		.cs_n   (cs_n),
		.dq_in  (dq_in),
		.dq_out (dq_out),
		.dq_oe  (dq_oe)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Checking

	task automatic stop_on_error();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: actual 0x%0h expected 0x%0h", name, actual, expected);
			stop_on_error();
		end
	endtask

	`include "qspi_host_tasks.svh"

	////////////////////////////////////////////////////////////
	// Reference model

	// Unmapped space reads as zero
	function automatic logic [7:0] expected_byte(input int addr);
		if (addr < mapped_size)
			return exp_mem[addr];
		return 8'h00;
	endfunction

	// Writes past the mapped range are dropped
	task automatic model_write(input int addr, input int len);
		for (int i = 0; i < len; i++)
			if (addr + i < mapped_size)
				exp_mem[addr + i] = burst_buf[i];
	endtask

	task automatic fill_random(input int len);
		for (int i = 0; i < len; i++)
			burst_buf[i] = 8'($urandom);
	endtask

	task automatic write_and_model(input int addr, input int len);
		fill_random(len);
		qspi_write_burst(16'(addr), len);
		model_write(addr, len);
	endtask

	task automatic read_and_compare(input int addr, input int len);
		qspi_read_burst(16'(addr), len);
		for (int i = 0; i < len; i++)
			check($sformatf("dq_out byte at 0x%0h", addr + i), 32'(burst_buf[i]),
				32'(expected_byte(addr + i)));
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_values();
		check("dq_oe", 32'(dq_oe), 32'h0);
		read_and_compare(0, 8);
	endtask

	// One byte per bank, offset differs per bank
	task automatic test_bank_single();
		for (int b = 0; b < num_banks; b++) begin
			write_and_model(b * bank_size + b * 5 + 3, 1);
			read_and_compare(b * bank_size + b * 5 + 3, 1);
		end
	endtask

	// Burst across the bank 0 to bank 1 edge
	task automatic test_boundary_burst();
		write_and_model(bank_size - 8, 16);
		read_and_compare(bank_size - 8, 16);
	endtask

	task automatic test_random_bursts();
		int addr;
		int len;
		for (int n = 0; n < 40; n++) begin
			addr = int'($urandom % mapped_size);
			len  = 1 + int'($urandom % 16);
			if ($urandom % 2)
				write_and_model(addr, len);
			else
				read_and_compare(addr, len);
		end
	endtask

	// Unmapped writes must not alias into bank 0
	task automatic test_unmapped();
		write_and_model(mapped_size, 8);
		read_and_compare(mapped_size, 8);
		read_and_compare(0, 8);
		write_and_model(mapped_size - 6, 12);
		read_and_compare(mapped_size - 6, 12);
	endtask

	task automatic test_cut_frame();
		logic [7:0] full_byte;
		burst_buf[0] = 8'h5a;
		burst_buf[1] = 8'hc3;
		qspi_write_burst(16'h0020, 2);
		model_write(32'h20, 2);
		full_byte = 8'($urandom);
		// One whole byte then half of the next
		open_frame(16'h8020);
		send_nibble(full_byte[7:4]);
		send_nibble(full_byte[3:0]);
		send_nibble(4'hf);
		close_frame();
		exp_mem[32'h20] = full_byte;
		// Next frame starts clean
		write_and_model(32'h30, 1);
		read_and_compare(32'h1f, 4);
		read_and_compare(32'h30, 1);
	endtask

	initial begin
		void'($urandom(32'hf47c));
		reset = 1'b1;
		sck   = 1'b0;
		cs_n  = 1'b1;
		dq_in = 4'h0;
		for (int i = 0; i < mapped_size; i++)
			exp_mem[i] = 8'h00;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		wait_clks(4);
		test_reset_values();
		test_bank_single();
		test_boundary_burst();
		test_random_bursts();
		test_unmapped();
		test_cut_frame();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire
